// ==== common/axi_burst_pkg.sv ====
// --------------------------------------------------
// AXI burst package
// Width typedefs and burst type codes shared by the
// burst master, the burst memory and the top level
// --------------------------------------------------
`default_nettype none

package axi_burst_pkg;

	// Beats minus one, as carried on awlen and arlen
	typedef logic [7:0] burst_len_t;

	// AXI size code, passed along with the burst
	typedef logic [2:0] burst_size_t;

	// AXI burst code
	typedef logic [1:0] burst_type_t;

	localparam burst_type_t BURST_FIXED = 2'd0; // Same address every beat
	localparam burst_type_t BURST_INCR  = 2'd1; // Word address plus one per beat

endpackage

`default_nettype wire

// ==== logic/beat_fifo.sv ====
// --------------------------------------------------
// Beat FIFO
// Synchronous circular buffer with a combinational
// head. Push and pop may happen in the same cycle
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module beat_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             resetn,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] head,
	output logic             full,
	output logic             empty
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]     buffer [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr, rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic                 do_push, do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			buffer[wr_ptr] <= push_data;
	end

	assign head  = buffer[rd_ptr];
	assign full  = (count == CNT_WIDTH'(DEPTH));
	assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== axi_master/axi_burst_master.sv ====
// --------------------------------------------------
// AXI burst master
// Write and read burst FSMs, one burst outstanding
// per direction. Write beats come from a buffer
// head and read beats go out as push strobes, with
// W and R gated by buffer availability
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_burst_master
	import axi_burst_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32
) (
	input  logic                    clk,
	input  logic                    resetn,

	// User write side
	input  logic                    start_write,
	input  logic [ADDR_WIDTH-1:0]   write_addr,
	input  burst_len_t              write_len,
	input  burst_size_t             write_size,
	input  burst_type_t             write_burst,
	input  logic [DATA_WIDTH/8-1:0] write_strb,
	input  logic [DATA_WIDTH-1:0]   write_data,     // Write buffer head
	input  logic                    write_data_avail,
	output logic                    write_data_take,
	output logic                    write_busy,
	output logic                    write_done,

	// User read side
	input  logic                    start_read,
	input  logic [ADDR_WIDTH-1:0]   read_addr,
	input  burst_len_t              read_len,
	input  burst_size_t             read_size,
	input  burst_type_t             read_burst,
	input  logic                    read_space,     // Read buffer not full
	output logic [DATA_WIDTH-1:0]   read_data,
	output logic                    read_beat,
	output logic                    read_busy,
	output logic                    read_done,

	// AW channel
	output logic [ADDR_WIDTH-1:0]   awaddr,
	output burst_len_t              awlen,
	output burst_size_t             awsize,
	output burst_type_t             awburst,
	output logic                    awvalid,
	input  logic                    awready,

	// W channel
	output logic [DATA_WIDTH-1:0]   wdata,
	output logic [DATA_WIDTH/8-1:0] wstrb,
	output logic                    wlast,
	output logic                    wvalid,
	input  logic                    wready,

	// B channel
	input  logic                    bvalid,
	output logic                    bready,

	// AR channel
	output logic [ADDR_WIDTH-1:0]   araddr,
	output burst_len_t              arlen,
	output burst_size_t             arsize,
	output burst_type_t             arburst,
	output logic                    arvalid,
	input  logic                    arready,

	// R channel
	input  logic                    rvalid,
	input  logic [DATA_WIDTH-1:0]   rdata,
	input  logic                    rlast,
	output logic                    rready
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} write_state_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} read_state_t;

	write_state_t            wr_state, wr_state_next;
	read_state_t             rd_state, rd_state_next;
	burst_len_t              wr_beat;  // Accepted W beats so far
	logic [DATA_WIDTH/8-1:0] wr_strb_q;
	logic                    w_fire;
	logic                    r_fire;

	assign w_fire = wvalid && wready;
	assign r_fire = rvalid && rready;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_state <= WR_IDLE;
			wr_beat  <= '0;
		end else begin
			wr_state <= wr_state_next;
			if (wr_state == WR_IDLE)
				wr_beat <= '0;
			else if (w_fire)
				wr_beat <= wr_beat + 8'd1;
		end
	end

	// Burst parameters held for the whole burst
	always_ff @(posedge clk) begin
		if (wr_state == WR_IDLE && start_write) begin
			awaddr    <= write_addr;
			awlen     <= write_len;
			awsize    <= write_size;
			awburst   <= write_burst;
			wr_strb_q <= write_strb;
		end
		if (rd_state == RD_IDLE && start_read) begin
			araddr  <= read_addr;
			arlen   <= read_len;
			arsize  <= read_size;
			arburst <= read_burst;
		end
	end

	always_comb begin
		wr_state_next = wr_state;
		case (wr_state)
			WR_IDLE: if (start_write) wr_state_next = WR_ADDR;
			WR_ADDR: if (awvalid && awready) wr_state_next = WR_DATA;
			WR_DATA: if (w_fire && wlast) wr_state_next = WR_RESP;
			WR_RESP: if (bvalid && bready) wr_state_next = WR_IDLE;
			default: wr_state_next = WR_IDLE;
		endcase
	end

	assign awvalid = (wr_state == WR_ADDR);
	assign wvalid  = (wr_state == WR_DATA) && write_data_avail; // Frozen while starved
	assign wdata   = write_data;
	assign wstrb   = wr_strb_q;
	assign wlast   = (wr_beat == awlen);
	assign bready  = (wr_state == WR_RESP);

	assign write_data_take = w_fire; // Pops the write buffer
	assign write_busy      = (wr_state != WR_IDLE);
	assign write_done      = bvalid && bready;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			rd_state <= RD_IDLE;
		else
			rd_state <= rd_state_next;
	end

	always_comb begin
		rd_state_next = rd_state;
		case (rd_state)
			RD_IDLE: if (start_read) rd_state_next = RD_ADDR;
			RD_ADDR: if (arvalid && arready) rd_state_next = RD_DATA;
			RD_DATA: if (r_fire && rlast) rd_state_next = RD_IDLE;
			default: rd_state_next = RD_IDLE;
		endcase
	end

	assign arvalid = (rd_state == RD_ADDR);
	assign rready  = (rd_state == RD_DATA) && read_space;

	// Each accepted R beat pushes the read buffer
	assign read_data = rdata;
	assign read_beat = r_fire;
	assign read_busy = (rd_state != RD_IDLE);
	assign read_done = r_fire && rlast;

endmodule

`default_nettype wire

// ==== axi_memory/axi_burst_memory.sv ====
// --------------------------------------------------
// AXI burst memory
// AXI slave over a word array. Independent write and
// read FSMs count their own burst addresses, writes
// merge bytes by strobe, reads are registered
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_burst_memory
	import axi_burst_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int MEM_WORDS  = 256
) (
	input  logic                    clk,
	input  logic                    resetn,

	input  logic [ADDR_WIDTH-1:0]   awaddr,
	input  burst_len_t              awlen,
	input  burst_size_t             awsize,   // Words are always full width
	input  burst_type_t             awburst,
	input  logic                    awvalid,
	output logic                    awready,

	input  logic [DATA_WIDTH-1:0]   wdata,
	input  logic [DATA_WIDTH/8-1:0] wstrb,
	input  logic                    wlast,
	input  logic                    wvalid,
	output logic                    wready,

	output logic                    bvalid,
	input  logic                    bready,

	input  logic [ADDR_WIDTH-1:0]   araddr,
	input  burst_len_t              arlen,
	input  burst_size_t             arsize,   // Same as awsize
	input  burst_type_t             arburst,
	input  logic                    arvalid,
	output logic                    arready,

	output logic                    rvalid,
	output logic [DATA_WIDTH-1:0]   rdata,
	output logic                    rlast,
	input  logic                    rready
);

	localparam int IDX_WIDTH = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {
		MW_IDLE,
		MW_DATA,
		MW_RESP
	} mem_write_state_t;

	typedef enum logic {
		MR_IDLE,
		MR_DATA
	} mem_read_state_t;

	logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

	mem_write_state_t      mw_state;
	logic [ADDR_WIDTH-1:0] mw_addr;
	burst_len_t            mw_len;
	burst_type_t           mw_burst;
	burst_len_t            mw_cnt;

	mem_read_state_t       mr_state;
	logic [ADDR_WIDTH-1:0] mr_addr;
	logic [ADDR_WIDTH-1:0] mr_next_addr;
	burst_len_t            mr_len;
	burst_type_t           mr_burst;
	burst_len_t            mr_cnt;

	logic aw_fire, w_fire, w_end, ar_fire, r_fire;

	// Word address wraps around the array
	function automatic logic [IDX_WIDTH-1:0] word_index(input logic [ADDR_WIDTH-1:0] addr);
		return IDX_WIDTH'(addr % MEM_WORDS);
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] step_addr(input logic [ADDR_WIDTH-1:0] addr,
			input burst_type_t burst);
		return (burst == BURST_INCR) ? addr + 1'b1 : addr;
	endfunction

	assign awready = (mw_state == MW_IDLE);
	assign wready  = (mw_state == MW_DATA);
	assign bvalid  = (mw_state == MW_RESP);
	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;
	assign w_end   = w_fire && (wlast || mw_cnt == mw_len); // Either marker closes the burst

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			mw_state <= MW_IDLE;
			mw_addr  <= '0;
			mw_len   <= '0;
			mw_burst <= BURST_FIXED;
			mw_cnt   <= '0;
		end else begin
			case (mw_state)
				MW_IDLE: if (aw_fire) begin
					mw_addr  <= awaddr;
					mw_len   <= awlen;
					mw_burst <= awburst;
					mw_cnt   <= '0;
					mw_state <= MW_DATA;
				end
				MW_DATA: if (w_fire) begin
					mw_addr <= step_addr(mw_addr, mw_burst);
					mw_cnt  <= mw_cnt + 8'd1;
					if (w_end)
						mw_state <= MW_RESP;
				end
				MW_RESP: if (bready) mw_state <= MW_IDLE;
				default: mw_state <= MW_IDLE;
			endcase
		end
	end

	// Byte lanes merged by strobe
	always_ff @(posedge clk) begin
		if (w_fire) begin
			for (int i = 0; i < DATA_WIDTH/8; i++)
				if (wstrb[i])
					mem[word_index(mw_addr)][8*i +: 8] <= wdata[8*i +: 8];
		end
	end

	assign arready      = (mr_state == MR_IDLE);
	assign rvalid       = (mr_state == MR_DATA);
	assign rlast        = rvalid && (mr_cnt == mr_len);
	assign ar_fire      = arvalid && arready;
	assign r_fire       = rvalid && rready;
	assign mr_next_addr = step_addr(mr_addr, mr_burst);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			mr_state <= MR_IDLE;
			mr_addr  <= '0;
			mr_len   <= '0;
			mr_burst <= BURST_FIXED;
			mr_cnt   <= '0;
		end else if (ar_fire) begin
			mr_addr  <= araddr;
			mr_len   <= arlen;
			mr_burst <= arburst;
			mr_cnt   <= '0;
			mr_state <= MR_DATA;
		end else if (r_fire) begin
			if (rlast) begin
				mr_state <= MR_IDLE;
			end else begin
				mr_addr <= mr_next_addr;
				mr_cnt  <= mr_cnt + 8'd1;
			end
		end
	end

	// Held while rready is low
	always_ff @(posedge clk) begin
		if (ar_fire)
			rdata <= mem[word_index(araddr)];
		else if (r_fire && !rlast)
			rdata <= mem[word_index(mr_next_addr)];
	end

endmodule

`default_nettype wire

// ==== logic/burst_copy_top.sv ====
// --------------------------------------------------
// Burst copy top level
// Write beat buffer, burst master, AXI burst memory
// and read beat buffer wired into one subsystem
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module burst_copy_top
	import axi_burst_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int MEM_WORDS  = 256,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                    clk,
	input  logic                    resetn,

	input  logic                    wr_push,
	input  logic [DATA_WIDTH-1:0]   wr_push_data,
	output logic                    wr_full,

	input  logic                    start_write,
	input  logic [ADDR_WIDTH-1:0]   write_addr,
	input  burst_len_t              write_len,
	input  burst_size_t             write_size,
	input  burst_type_t             write_burst,
	input  logic [DATA_WIDTH/8-1:0] write_strb,
	output logic                    write_busy,
	output logic                    write_done,

	input  logic                    start_read,
	input  logic [ADDR_WIDTH-1:0]   read_addr,
	input  burst_len_t              read_len,
	input  burst_size_t             read_size,
	input  burst_type_t             read_burst,
	output logic                    read_busy,
	output logic                    read_done,

	input  logic                    rd_pop,
	output logic [DATA_WIDTH-1:0]   rd_pop_data,
	output logic                    rd_empty
);

	logic [DATA_WIDTH-1:0]   write_data, read_data;
	logic                    write_data_take, wbuf_empty;
	logic                    read_beat, rbuf_full;

	logic [ADDR_WIDTH-1:0]   awaddr, araddr;
	burst_len_t              awlen, arlen;
	burst_size_t             awsize, arsize;
	burst_type_t             awburst, arburst;
	logic                    awvalid, awready, arvalid, arready;
	logic [DATA_WIDTH-1:0]   wdata, rdata;
	logic [DATA_WIDTH/8-1:0] wstrb;
	logic                    wlast, wvalid, wready, bvalid, bready;
	logic                    rvalid, rlast, rready;

	beat_fifo #(.WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_write_buf (
		.clk, .resetn,
		.push(wr_push), .push_data(wr_push_data), .pop(write_data_take),
		.head(write_data), .full(wr_full), .empty(wbuf_empty)
	);

	axi_burst_master #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_master (
		.clk, .resetn,
		.start_write, .write_addr, .write_len, .write_size, .write_burst, .write_strb,
		.write_data, .write_data_avail(!wbuf_empty), .write_data_take,
		.write_busy, .write_done,
		.start_read, .read_addr, .read_len, .read_size, .read_burst,
		.read_space(!rbuf_full), .read_data, .read_beat, .read_busy, .read_done,
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wstrb, .wlast, .wvalid, .wready, .bvalid, .bready,
		.araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
		.rvalid, .rdata, .rlast, .rready
	);

	axi_burst_memory #(
		.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)
	) u_memory (
		.clk, .resetn,
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wstrb, .wlast, .wvalid, .wready, .bvalid, .bready,
		.araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
		.rvalid, .rdata, .rlast, .rready
	);

	// Fed by accepted R beats
	beat_fifo #(.WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_read_buf (
		.clk, .resetn,
		.push(read_beat), .push_data(read_data), .pop(rd_pop),
		.head(rd_pop_data), .full(rbuf_full), .empty(rd_empty)
	);

endmodule

`default_nettype wire

// ==== bench/tb_burst_model.svh ====
// --------------------------------------------------
// Burst copy reference model
// Shadow word memory with INCR and FIXED burst
// addressing and the strobe byte merge, plus the
// expected word for each beat of a read burst
// --------------------------------------------------
`ifndef TB_BURST_MODEL_SVH
`define TB_BURST_MODEL_SVH

localparam int MODEL_WORDS = 256;

logic [31:0] shadow_mem [MODEL_WORDS];
logic [31:0] beat_data [16];  // Words of the current write burst

// Word index of one beat, wrapping around the memory
function automatic int model_index(input logic [31:0] addr, input burst_type_t burst,
		input int beat);
	if (burst == BURST_INCR)
		return int'((addr + beat) % MODEL_WORDS);
	return int'(addr % MODEL_WORDS); // FIXED keeps the start address
endfunction

// Applies a whole write burst to the shadow memory
function automatic void model_write_burst(input logic [31:0] addr, input burst_len_t len,
		input burst_type_t burst, input logic [3:0] strb);
	int idx;
	for (int b = 0; b <= int'(len); b++) begin
		idx = model_index(addr, burst, b);
		for (int lane = 0; lane < 4; lane++)
			if (strb[lane])
				shadow_mem[idx][8*lane +: 8] = beat_data[b][8*lane +: 8];
	end
endfunction

// Expected word on one beat of a read burst
function automatic logic [31:0] expected_read_word(input logic [31:0] addr,
		input burst_type_t burst, input int beat);
	return shadow_mem[model_index(addr, burst, beat)];
endfunction

`endif

// ==== bench/tb_burst_copy.sv ====
// --------------------------------------------------
// Burst copy testbench
// Loads write beats, runs write and read bursts
// through the burst copy subsystem and checks every
// popped word against the reference model
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_burst_copy
	import axi_burst_pkg::*;
;

	localparam int WAIT_LIMIT = 300;
	localparam int W_DONE = 0, R_DONE = 1, W_SPACE = 2, R_DATA = 3, R_FULL = 4;

	logic        clk, resetn;
	logic        wr_push, wr_full, start_write, write_busy, write_done;
	logic [31:0] wr_push_data, write_addr, read_addr, rd_pop_data;
	burst_len_t  write_len, read_len;
	burst_size_t write_size, read_size;
	burst_type_t write_burst, read_burst;
	logic [3:0]  write_strb;
	logic        start_read, read_busy, read_done, rd_pop, rd_empty;

	integer      seed = 32'hb45b884b;
	int          write_goal, read_goal, write_done_count, read_done_count;
	logic [31:0] exp_q[$];  // Expected words in pop order

	`include "tb_burst_model.svh"

	burst_copy_top UUT (
		.clk, .resetn, .wr_push, .wr_push_data, .wr_full,
		.start_write, .write_addr, .write_len, .write_size, .write_burst, .write_strb,
		.write_busy, .write_done,
		.start_read, .read_addr, .read_len, .read_size, .read_burst,
		.read_busy, .read_done, .rd_pop, .rd_pop_data, .rd_empty
	);

	always #20 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	// Done pulses counted and popped words compared on the edge that takes them
	always @(posedge clk) begin
		if (!resetn) begin
			write_done_count <= 0;
			read_done_count  <= 0;
		end else begin
			if (write_done) write_done_count <= write_done_count + 1;
			if (read_done)  read_done_count  <= read_done_count + 1;
			if (rd_pop && !rd_empty) begin
				if (exp_q.size() == 0)
					fail_run("Read buffer popped while no word was expected");
				else
					check_value("rd_pop_data", rd_pop_data, exp_q.pop_front());
			end
		end
	end

	function automatic bit cond_met(input int cond);
		case (cond)
			W_DONE:  return write_done_count >= write_goal;
			R_DONE:  return read_done_count >= read_goal;
			W_SPACE: return !wr_full;
			R_DATA:  return !rd_empty;
			default: return UUT.rbuf_full;
		endcase
	endfunction

	task automatic wait_for(input int cond, input string what);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!cond_met(cond)) begin
			if (cycles == WAIT_LIMIT)
				fail_run({"Timed out waiting for ", what});
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic make_words(input int n);
		for (int i = 0; i < n; i++)
			beat_data[i] = $random(seed);
	endtask

	task automatic push_words(input int first, input int n);
		for (int i = first; i < first + n; i++) begin
			wait_for(W_SPACE, "space in the write buffer");
			@(posedge clk);
			wr_push      <= 1'b1;
			wr_push_data <= beat_data[i];
			@(posedge clk);
			wr_push <= 1'b0;
		end
	endtask

	task automatic pop_words(input int n);
		repeat (n) begin
			wait_for(R_DATA, "a word in the read buffer");
			@(posedge clk);
			rd_pop <= 1'b1;
			@(posedge clk);
			rd_pop <= 1'b0;
		end
	endtask

	task automatic start_write_burst(input logic [31:0] addr, input burst_len_t len,
			input burst_type_t burst, input logic [3:0] strb);
		model_write_burst(addr, len, burst, strb);
		write_goal++;
		@(posedge clk);
		start_write <= 1'b1;
		write_addr  <= addr;
		write_len   <= len;
		write_size  <= 3'd2; // Four bytes per beat
		write_burst <= burst;
		write_strb  <= strb;
		@(posedge clk);
		start_write <= 1'b0;
	endtask

	task automatic start_read_burst(input logic [31:0] addr, input burst_len_t len,
			input burst_type_t burst);
		for (int b = 0; b <= int'(len); b++)
			exp_q.push_back(expected_read_word(addr, burst, b));
		read_goal++;
		@(posedge clk);
		start_read <= 1'b1;
		read_addr  <= addr;
		read_len   <= len;
		read_size  <= 3'd2;
		read_burst <= burst;
		@(posedge clk);
		start_read <= 1'b0;
	endtask

	task automatic finish_write();
		wait_for(W_DONE, "write_done");
		check_value("write_done count", write_done_count, write_goal);
	endtask

	task automatic finish_read(input int beats);
		pop_words(beats);
		wait_for(R_DONE, "read_done");
		check_value("read_done count", read_done_count, read_goal);
		check_value("rd_empty", rd_empty, 1); // No extra beat left behind
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		wr_push = 1'b0;
		wr_push_data = '0;
		start_write = 1'b0;
		write_addr = '0;
		write_len = '0;
		write_size = '0;
		write_burst = BURST_FIXED;
		write_strb = '0;
		start_read = 1'b0;
		read_addr = '0;
		read_len = '0;
		read_size = '0;
		read_burst = BURST_FIXED;
		rd_pop = 1'b0;
		write_goal = 0;
		read_goal = 0;
		repeat (16) @(posedge clk);
		resetn <= 1'b1;

		// Idle state after reset
		repeat (8) @(posedge clk);
		@(negedge clk);
		check_value("wr_full", wr_full, 0);
		check_value("rd_empty", rd_empty, 1);
		check_value("write_busy", write_busy, 0);
		check_value("read_busy", read_busy, 0);
		check_value("write_done count", write_done_count, 0);
		check_value("read_done count", read_done_count, 0);

		// INCR round trip
		make_words(4);
		push_words(0, 4);
		start_write_burst(32'h10, 8'd3, BURST_INCR, 4'hf);
		finish_write();
		start_read_burst(32'h10, 8'd3, BURST_INCR);
		finish_read(4);

		// Partial strobe over the same range
		make_words(4);
		push_words(0, 4);
		start_write_burst(32'h10, 8'd3, BURST_INCR, 4'b0101);
		finish_write();
		start_read_burst(32'h10, 8'd3, BURST_INCR);
		finish_read(4);

		// FIXED write keeps only the last beat
		make_words(3);
		push_words(0, 3);
		start_write_burst(32'h40, 8'd2, BURST_FIXED, 4'hf);
		finish_write();
		start_read_burst(32'h40, 8'd3, BURST_FIXED);
		finish_read(4);

		// Starved write buffer
		make_words(6);
		push_words(0, 2);
		start_write_burst(32'h20, 8'd5, BURST_INCR, 4'hf);
		repeat (20) @(posedge clk);
		@(negedge clk);
		check_value("write_done count", write_done_count, write_goal - 1);
		check_value("write_busy", write_busy, 1);
		push_words(2, 4);
		finish_write();
		start_read_burst(32'h20, 8'd5, BURST_INCR);
		finish_read(6);

		// 16 beats through a full read buffer
		make_words(16);
		start_write_burst(32'h80, 8'd15, BURST_INCR, 4'hf);
		push_words(0, 16);
		finish_write();
		start_read_burst(32'h80, 8'd15, BURST_INCR);
		wait_for(R_FULL, "the read buffer to fill");
		check_value("read_busy", read_busy, 1);
		check_value("read_done count", read_done_count, read_goal - 1);
		finish_read(16);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+bench
common/axi_burst_pkg.sv
logic/beat_fifo.sv
axi_master/axi_burst_master.sv
axi_memory/axi_burst_memory.sv
logic/burst_copy_top.sv
bench/tb_burst_copy.sv
